/* lockstep_params.svh */
`ifndef LOCKSTEP_PARAMS_SVH
`define LOCKSTEP_PARAMS_SVH

// Cycles the shadow core trails the main core, at least 2
`define LOCKSTEP_OFFSET 2

// Bus geometry
`define BUS_W  32
`define INTG_W 7
`define BE_W   4

// Checksum stores always target this word
`define CSUM_ADDR 32'h0000_1000

// Data bits covered by each SECDED 39/32 check bit
`define SECDED_MASK0 32'h2606_BD25
`define SECDED_MASK1 32'hDEBA_8050
`define SECDED_MASK2 32'h413D_89AA
`define SECDED_MASK3 32'h3123_4ED1
`define SECDED_MASK4 32'hC2C1_323B
`define SECDED_MASK5 32'h2DCC_624C
`define SECDED_MASK6 32'h9850_5586

// Check bits travel inverted, so an all-zero word is never a valid codeword
`define SECDED_INV 7'h2A

`endif

/* lockstep_pkg.sv */
`include "lockstep_params.svh"

package lockstep_pkg;

  typedef logic [`BUS_W-1:0]  bus_word_t;
  typedef logic [`INTG_W-1:0] intg_t;
  typedef logic [`BE_W-1:0]   be_t;

  // Bus signals a core receives
  typedef struct packed {
    logic      instr_gnt;
    logic      instr_rvalid;
    bus_word_t instr_rdata;
    logic      instr_err;
    logic      data_gnt;
    logic      data_rvalid;
    bus_word_t data_rdata;
    logic      data_err;
    logic      fetch_enable;
  } core_in_t;

  // Signals a core drives, all of them compared between the copies
  typedef struct packed {
    logic      instr_req;
    bus_word_t instr_addr;
    logic      data_req;
    logic      data_we;
    be_t       data_be;
    bus_word_t data_addr;
    bus_word_t data_wdata;
  } core_out_t;

  typedef enum logic {
    RST_HOLD,
    RST_RUN
  } rst_seq_e;

  localparam logic [`INTG_W-1:0][`BUS_W-1:0] SECDED_MASKS = {
    `SECDED_MASK6, `SECDED_MASK5, `SECDED_MASK4, `SECDED_MASK3,
    `SECDED_MASK2, `SECDED_MASK1, `SECDED_MASK0
  };

  function automatic intg_t secded_encode(bus_word_t data);
    intg_t check;
    for (int i = 0; i < `INTG_W; i++) begin
      check[i] = ^(data & SECDED_MASKS[i]);
    end
    return check ^ `SECDED_INV;
  endfunction

  // Zero for a clean codeword, nonzero for a single or double bit error
  function automatic intg_t secded_syndrome(bus_word_t data, intg_t intg);
    return secded_encode(data) ^ intg;
  endfunction

endpackage

/* shadow_reset_ctrl.sv */
`include "lockstep_params.svh"

module shadow_reset_ctrl import lockstep_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  output logic rst_shadow_no,
  output logic cmp_en_o
);

  localparam int unsigned CNT_W = $clog2(`LOCKSTEP_OFFSET);

  rst_seq_e         state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             cmp_en_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= RST_HOLD;
      cnt_q    <= '0;
      cmp_en_q <= 1'b0;
    end else begin
      // Comparison starts one cycle after the shadow leaves reset
      cmp_en_q <= (state_q == RST_RUN);
      if (state_q == RST_HOLD) begin
        if (cnt_q == CNT_W'(`LOCKSTEP_OFFSET - 1)) begin
          state_q <= RST_RUN;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // Straight from the state flop, so the shadow reset is glitch free
  assign rst_shadow_no = (state_q == RST_RUN);
  assign cmp_en_o      = cmp_en_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmp_en_o) |-> rst_shadow_no && $past(rst_shadow_no));

endmodule

/* input_delay.sv */
`include "lockstep_params.svh"

module input_delay import lockstep_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  core_in_t main_in_i,
  input  intg_t    instr_rdata_intg_i,
  input  intg_t    data_rdata_intg_i,
  output core_in_t shadow_in_o,
  output core_in_t newest_in_o,
  output intg_t    instr_intg_o,
  output intg_t    data_intg_o
);

  localparam int unsigned DEPTH = `LOCKSTEP_OFFSET;

  // Index DEPTH-1 takes the bus inputs, index 0 feeds the shadow core
  core_in_t [DEPTH-1:0] stage_q;
  intg_t                instr_intg_q;
  intg_t                data_intg_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q      <= '0;
      instr_intg_q <= '0;
      data_intg_q  <= '0;
    end else begin
      for (int unsigned i = 0; i < DEPTH - 1; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      stage_q[DEPTH-1] <= main_in_i;
      // Check bits only need to line up with the newest stage
      instr_intg_q <= instr_rdata_intg_i;
      data_intg_q  <= data_rdata_intg_i;
    end
  end

  assign shadow_in_o  = stage_q[0];
  assign newest_in_o  = stage_q[DEPTH-1];
  assign instr_intg_o = instr_intg_q;
  assign data_intg_o  = data_intg_q;

endmodule

/* bus_intg_check.sv */
module bus_intg_check import lockstep_pkg::*; (
  input  core_in_t  newest_in_i,
  input  intg_t     instr_intg_i,
  input  intg_t     data_intg_i,
  input  bus_word_t main_wdata_i,
  output intg_t     data_wdata_intg_o,
  output logic      bus_intg_err_o
);

  intg_t instr_syndrome;
  intg_t data_syndrome;
  logic  instr_intg_err;
  logic  data_intg_err;

  // Read data is checked as it enters the delay line, well ahead of the shadow
  assign instr_syndrome = secded_syndrome(newest_in_i.instr_rdata, instr_intg_i);
  assign data_syndrome  = secded_syndrome(newest_in_i.data_rdata, data_intg_i);

  // Only beats flagged by rvalid carry meaningful data
  assign instr_intg_err = newest_in_i.instr_rvalid & (|instr_syndrome);
  assign data_intg_err  = newest_in_i.data_rvalid & (|data_syndrome);

  assign bus_intg_err_o = instr_intg_err | data_intg_err;

  // Write data leaves with fresh check bits
  assign data_wdata_intg_o = secded_encode(main_wdata_i);

endmodule

/* fetch_core.sv */
`include "lockstep_params.svh"

module fetch_core import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  core_in_t  core_in_i,
  output core_out_t core_out_o,
  output logic      alert_minor_o,
  output logic      alert_major_o
);

  bus_word_t fetch_addr_q;
  bus_word_t csum_q;
  logic      store_q;
  logic      fetch_req;
  logic      fetch_done;
  logic      csum_upd;

  assign fetch_req  = core_in_i.fetch_enable;
  assign fetch_done = fetch_req & core_in_i.instr_gnt;
  // Error responses never reach the checksum
  assign csum_upd   = core_in_i.instr_rvalid & ~core_in_i.instr_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
      csum_q       <= '0;
      store_q      <= 1'b0;
    end else begin
      if (fetch_done) begin
        fetch_addr_q <= fetch_addr_q + bus_word_t'(4);
      end
      if (csum_upd) begin
        csum_q <= csum_q ^ core_in_i.instr_rdata;
      end
      // A word arriving during a store is folded in and carried by the next store
      store_q <= csum_upd & ~store_q;
    end
  end

  always_comb begin
    core_out_o.instr_req  = fetch_req;
    core_out_o.instr_addr = fetch_addr_q;
    core_out_o.data_req   = store_q;
    core_out_o.data_we    = store_q;
    core_out_o.data_be    = {`BE_W{store_q}};
    core_out_o.data_addr  = `CSUM_ADDR;
    core_out_o.data_wdata = csum_q;
  end

  assign alert_minor_o = core_in_i.instr_rvalid & core_in_i.instr_err;
  assign alert_major_o = core_in_i.data_rvalid & core_in_i.data_err;

  // Checksum stores are single-cycle pulses, data_gnt is never awaited
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_out_o.data_req |=> !core_out_o.data_req);

endmodule

/* output_compare.sv */
`include "lockstep_params.svh"

module output_compare import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cmp_en_i,
  input  core_out_t main_out_i,
  input  core_out_t shadow_out_i,
  input  logic      shadow_alert_minor_i,
  input  logic      shadow_alert_major_i,
  input  logic      bus_intg_err_i,
  output logic      alert_minor_o,
  output logic      alert_major_o
);

  // One extra stage matches the shadow output register
  localparam int unsigned OUT_DEPTH = `LOCKSTEP_OFFSET + 1;

  core_out_t [OUT_DEPTH-1:0] main_q;
  core_out_t                 shadow_q;
  logic                      shadow_minor_q;
  logic                      shadow_major_q;
  logic                      mismatch;

  // Main output delay line and shadow output register
  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < OUT_DEPTH - 1; i++) begin
      main_q[i] <= main_q[i+1];
    end
    main_q[OUT_DEPTH-1] <= main_out_i;
    shadow_q            <= shadow_out_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_minor_q <= 1'b0;
      shadow_major_q <= 1'b0;
    end else begin
      shadow_minor_q <= shadow_alert_minor_i;
      shadow_major_q <= shadow_alert_major_i;
    end
  end

  assign mismatch      = cmp_en_i & (main_q[0] != shadow_q);
  assign alert_major_o = mismatch | shadow_major_q | bus_intg_err_i;
  assign alert_minor_o = shadow_minor_q;

  // Before comparison starts only a read integrity error may raise the major alert
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!cmp_en_i && !bus_intg_err_i) |-> !alert_major_o);

endmodule

/* lockstep_top.sv */
module lockstep_top import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  core_in_t  main_in_i,
  input  intg_t     instr_rdata_intg_i,
  input  intg_t     data_rdata_intg_i,
  input  core_out_t main_out_i,
  output intg_t     data_wdata_intg_o,
  output logic      alert_minor_o,
  output logic      alert_major_o
);

  logic      rst_shadow_n;
  logic      cmp_en;
  core_in_t  shadow_in;
  core_in_t  newest_in;
  intg_t     instr_intg;
  intg_t     data_intg;
  logic      bus_intg_err;
  core_out_t shadow_out;
  logic      shadow_alert_minor;
  logic      shadow_alert_major;

  shadow_reset_ctrl u_rst_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rst_shadow_no (rst_shadow_n),
    .cmp_en_o      (cmp_en)
  );

  //////////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////////

  input_delay u_input_delay (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .main_in_i          (main_in_i),
    .instr_rdata_intg_i (instr_rdata_intg_i),
    .data_rdata_intg_i  (data_rdata_intg_i),
    .shadow_in_o        (shadow_in),
    .newest_in_o        (newest_in),
    .instr_intg_o       (instr_intg),
    .data_intg_o        (data_intg)
  );

  bus_intg_check u_intg_check (
    .newest_in_i       (newest_in),
    .instr_intg_i      (instr_intg),
    .data_intg_i       (data_intg),
    .main_wdata_i      (main_out_i.data_wdata),
    .data_wdata_intg_o (data_wdata_intg_o),
    .bus_intg_err_o    (bus_intg_err)
  );

  //////////////////////////////////////////////////////////////////////////
  // Shadow copy and compare
  //////////////////////////////////////////////////////////////////////////

  fetch_core u_shadow_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_shadow_n),
    .core_in_i     (shadow_in),
    .core_out_o    (shadow_out),
    .alert_minor_o (shadow_alert_minor),
    .alert_major_o (shadow_alert_major)
  );

  output_compare u_output_compare (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cmp_en_i             (cmp_en),
    .main_out_i           (main_out_i),
    .shadow_out_i         (shadow_out),
    .shadow_alert_minor_i (shadow_alert_minor),
    .shadow_alert_major_i (shadow_alert_major),
    .bus_intg_err_i       (bus_intg_err),
    .alert_minor_o        (alert_minor_o),
    .alert_major_o        (alert_major_o)
  );

endmodule

/* tb_lockstep.sv */
`include "lockstep_params.svh"

module tb_lockstep import lockstep_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NCOL = 15;

  // One cycle of stimulus with the bus columns in core_in_t order
  typedef struct packed {
    core_in_t   bus;
    logic [1:0] rnd;
    bus_word_t  fault;
    intg_t      iflip;
    intg_t      dflip;
    logic       exp_minor;
    logic       exp_major;
  } pat_t;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  core_in_t  main_in;
  intg_t     instr_intg;
  intg_t     data_intg;
  bus_word_t fault_mask;
  core_out_t main_out;
  core_out_t dut_main_out;
  intg_t     wdata_intg;
  logic      alert_minor;
  logic      alert_major;

  pat_t        pat_q[$];
  logic [31:0] lfsr_state = 32'h2429;
  int unsigned cycle_cnt  = 0;
  // Reference checksum and expected store pulse
  bus_word_t   csum_model = '0;
  logic        store_exp  = 1'b0;
  logic        fold_now;
  bus_word_t   fold_word;

  fetch_core u_main_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_in_i     (main_in),
    .core_out_o    (main_out),
    .alert_minor_o (),
    .alert_major_o ()
  );

  lockstep_top dut_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .main_in_i          (main_in),
    .instr_rdata_intg_i (instr_intg),
    .data_rdata_intg_i  (data_intg),
    .main_out_i         (dut_main_out),
    .data_wdata_intg_o  (wdata_intg),
    .alert_minor_o      (alert_minor),
    .alert_major_o      (alert_major)
  );

  // Faults only touch the copy of the write data that the checker sees
  always_comb begin
    dut_main_out            = main_out;
    dut_main_out.data_wdata = main_out.data_wdata ^ fault_mask;
  end

  initial begin
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= pat_q.size() + 40) begin
      $display("timeout: patterns still running after %0d cycles", cycle_cnt);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic bus_word_t rand_word();
    bus_word_t w = '0;
    for (int i = 0; i < `BUS_W; i++) begin
      w          = {w[`BUS_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("mismatch %s at %0t: got 0x%08h, expected 0x%08h", name, $time, got, want);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    logic [31:0] c [NCOL];
    fd = $fopen("lockstep_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open lockstep_patterns.txt");
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7],
                  c[8], c[9], c[10], c[11], c[12], c[13], c[14]);
      if (n == NCOL) begin
        pat_q.push_back({c[0][0], c[1][0], c[2], c[3][0], c[4][0], c[5][0], c[6],
                         c[7][0], c[8][0], c[9][1:0], c[10], c[11][6:0], c[12][6:0],
                         c[13][0], c[14][0]});
      end else if (n > 0) begin
        $display("pattern line has %0d columns instead of %0d: %s", n, NCOL, line);
        $display("TESTBENCH FAILED");
        $fatal(1);
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_line(input pat_t p);
    core_in_t bus;
    bus = p.bus;
    if (p.rnd[0]) begin
      bus.instr_rdata = rand_word();
    end
    if (p.rnd[1]) begin
      bus.data_rdata = rand_word();
    end
    main_in    <= bus;
    instr_intg <= secded_encode(bus.instr_rdata) ^ p.iflip;
    data_intg  <= secded_encode(bus.data_rdata) ^ p.dflip;
    fault_mask <= p.fault;
    // A clean instruction beat is folded and stored one cycle later
    fold_now  = bus.instr_rvalid & ~bus.instr_err;
    fold_word = bus.instr_rdata;
  endtask

  task automatic check_line(input pat_t p);
    check("main instr_req", main_out.instr_req, p.bus.fetch_enable);
    check("main data_req", main_out.data_req, store_exp);
    if (store_exp) begin
      check("main data_wdata", main_out.data_wdata, csum_model);
      check("main data_addr", main_out.data_addr, `CSUM_ADDR);
      check("data_wdata_intg_o", wdata_intg, secded_encode(csum_model ^ p.fault));
    end
    check("alert_minor_o", alert_minor, p.exp_minor);
    check("alert_major_o", alert_major, p.exp_major);
    if (fold_now) begin
      csum_model = csum_model ^ fold_word;
    end
    store_exp = fold_now;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni     = 1'b0;
    main_in    = '0;
    load_patterns();
    if (pat_q.size() == 0) begin
      $display("no stimulus lines found in lockstep_patterns.txt");
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
    // Corrupted write data and bad read check bits while in reset
    main_in.instr_rvalid = 1'b1;
    main_in.data_rvalid  = 1'b1;
    instr_intg           = 7'h01;
    data_intg            = 7'h01;
    fault_mask           = '1;
    repeat (16) begin
      @(negedge clk_i);
      check("alert_minor_o", alert_minor, 0);
      check("alert_major_o", alert_major, 0);
    end
    for (int k = 0; k < pat_q.size(); k++) begin
      @(posedge clk_i);
      rst_ni <= 1'b1;
      drive_line(pat_q[k]);
      @(negedge clk_i);
      check_line(pat_q[k]);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* lockstep_patterns.txt */
// ig iv instr_rdata ie dg dv data_rdata de fe rnd fault_mask instr_flip data_flip minor major
// rnd bit 0 and bit 1 replace instr_rdata and data_rdata with LFSR words
0 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 0
1 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 0
1 1 00000000 0 0 0 00000000 0 1 1 00000000 00 00 0 0
0 0 00000000 0 1 0 00000000 0 1 0 00000000 00 00 0 0
1 1 12345678 0 0 0 00000000 0 1 0 00000000 00 00 0 0
0 0 00000000 0 0 0 00000000 0 1 0 000000FF 00 00 0 0
1 1 00000000 0 0 0 00000000 0 1 1 00000000 00 00 0 0
0 0 00000000 0 1 0 00000000 0 1 0 00000000 00 00 0 0
0 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 1
0 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 0
1 1 00000000 0 0 0 00000000 0 1 1 00000000 01 00 0 0
0 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 1
0 0 00000000 0 0 1 00000000 0 1 2 00000000 00 40 0 0
0 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 1
0 0 00000000 0 0 0 00000000 0 1 0 00000000 03 10 0 0
0 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 0
1 1 DEADBEEF 1 0 0 00000000 0 1 0 00000000 00 00 0 0
0 0 00000000 0 0 1 00000000 1 1 0 00000000 00 00 0 0
1 0 00000000 0 0 0 00000000 0 0 0 00000000 00 00 0 0
0 0 00000000 0 0 0 00000000 0 0 0 00000000 00 00 1 0
0 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 1
1 1 00000000 0 0 0 00000000 0 1 1 00000000 00 00 0 0
0 0 00000000 0 0 0 00000000 0 1 0 80000000 00 00 0 0
0 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 0
0 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 0
0 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 1
0 0 00000000 0 0 0 00000000 0 1 0 00000000 00 00 0 0

/* filelist.f */
+incdir+.
lockstep_pkg.sv
shadow_reset_ctrl.sv
input_delay.sv
bus_intg_check.sv
fetch_core.sv
output_compare.sv
lockstep_top.sv
tb_lockstep.sv

/* Bender.yml */
package:
  name: lockstep_checker

export_include_dirs:
  - .

sources:
  - lockstep_pkg.sv
  - shadow_reset_ctrl.sv
  - input_delay.sv
  - bus_intg_check.sv
  - fetch_core.sv
  - output_compare.sv
  - lockstep_top.sv
  - target: test
    files:
      - tb_lockstep.sv
